/* rtl/activity_led.sv */
`timescale 1ns/1ps
`default_nettype none

module activity_led #(
	parameter int unsigned LED_HOLD = 4500000
) (
	input  logic clk_sys,
	input  logic reset_delayed,
	input  logic pulse,
	output logic lit
);

	localparam int CW = $clog2(LED_HOLD + 1);

	// Remaining lit cycles after the current one
	logic [CW-1:0] hold_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			hold_cnt <= '0;
			lit      <= 1'b0;
		end else begin
			if (pulse)
				hold_cnt <= CW'(LED_HOLD - 1);
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;

			lit <= pulse | (hold_cnt != '0);
		end
	end

endmodule

`default_nettype wire

/* rtl/clock_enable_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_enable_gen
	import glue_core_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset_delayed,
	input  logic           turbo,
	input  logic           snd_clockmode,
	output clock_enables_t enables
);

	////////////////////////////////////////
	// Dividers
	////////////////////////////////////////

	logic [1:0] div_sys;
	logic [2:0] div_snd5;
	logic [3:0] div_snd10;
	logic [4:0] div_opm;

	// Turbo as seen by the processor enables
	logic turbo_q;

	logic sys_wrap;
	logic snd5_wrap;
	logic snd10_wrap;
	logic opm_wrap;

	assign sys_wrap   = (div_sys == 2'd3);
	assign snd5_wrap  = (div_snd5 == 3'd4);
	assign snd10_wrap = (div_snd10 == 4'd9);
	assign opm_wrap   = (div_opm == 5'd19);

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			div_sys   <= '0;
			div_snd5  <= '0;
			div_snd10 <= '0;
			div_opm   <= '0;
			turbo_q   <= 1'b0;
		end else begin
			div_sys   <= div_sys + 2'd1;
			div_snd5  <= snd5_wrap ? 3'd0 : div_snd5 + 3'd1;
			div_snd10 <= snd10_wrap ? 4'd0 : div_snd10 + 4'd1;
			div_opm   <= opm_wrap ? 5'd0 : div_opm + 5'd1;

			// Only change speed on a system period boundary
			if (sys_wrap)
				turbo_q <= turbo;
		end
	end

	////////////////////////////////////////
	// Registered enables
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			enables <= '0;
		end else begin
			enables.sys_ce <= sys_wrap;

			// Turbo runs both phases on alternate cycles
			enables.mpu_cep <= turbo_q ? div_sys[0] : (div_sys == 2'd3);
			enables.mpu_cen <= turbo_q ? ~div_sys[0] : (div_sys == 2'd1);

			enables.snd_ce <= snd_clockmode ? snd10_wrap : snd5_wrap;
			enables.opm_ce <= {opm_wrap, snd10_wrap};
		end
	end

endmodule

`default_nettype wire

/* rtl/core_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module core_glue
	import glue_menu_pkg::*;
	import glue_core_pkg::*;
#(
	parameter logic [23:0] MOUNT_HOLD   = 24'hffffff,
	parameter int unsigned EJECT_WINDOW = 65536,
	parameter int unsigned EJECT_HOLD   = 65535,
	parameter int unsigned RESET_HOLD   = 65535,
	parameter int unsigned LED_HOLD     = 4500000
) (
	input  logic           clk_sys,
	input  logic           reset_delayed,
	input  logic [63:0]    status,
	input  logic           ext_reset,
	input  logic           user_button,
	input  logic [3:0]     img_mounted,
	input  logic           download,
	input  loader_req_t    loader_req,
	input  logic           core_ack,
	input  logic           snd_clockmode,
	input  logic           hdd_activity,
	input  logic           fdd_motor,
	output clock_enables_t enables,
	output disk_status_t   disks,
	output logic           core_reset,
	output logic           core_run,
	output loader_ctl_t    loader_ctl,
	output logic [19:0]    core_addr,
	output logic [7:0]     core_data,
	output logic           hdd_led,
	output logic           fdd_led,
	output menu_requests_t requests
);

	menu_settings_t settings;
	logic           held_reset;

	////////////////////////////////////////
	// Menu decode
	////////////////////////////////////////

	menu_status_decode u_decode (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.status        (status),
		.settings      (settings),
		.requests      (requests),
		.held_reset    (held_reset)
	);

	////////////////////////////////////////
	// Clocking, reset and loader
	////////////////////////////////////////

	clock_enable_gen u_clk_en (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.turbo         (settings.turbo),
		.snd_clockmode (snd_clockmode),
		.enables       (enables)
	);

	reset_sequencer #(
		.MOUNT_HOLD   (MOUNT_HOLD),
		.EJECT_WINDOW (EJECT_WINDOW),
		.EJECT_HOLD   (EJECT_HOLD),
		.RESET_HOLD   (RESET_HOLD)
	) u_reset_seq (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.requests      (requests),
		.held_reset    (held_reset),
		.user_button   (user_button),
		.ext_reset     (ext_reset),
		.download      (download),
		.img_mounted   (img_mounted),
		.disks         (disks),
		.core_reset    (core_reset),
		.core_run      (core_run)
	);

	loader_bridge u_loader (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.download      (download),
		.req           (loader_req),
		.core_ack      (core_ack),
		.ctl           (loader_ctl),
		.core_addr     (core_addr),
		.core_data     (core_data)
	);

	// Activity indicators
	activity_led #(.LED_HOLD(LED_HOLD)) u_hdd_led (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.pulse         (hdd_activity),
		.lit           (hdd_led)
	);

	activity_led #(.LED_HOLD(LED_HOLD)) u_fdd_led (
		.clk_sys       (clk_sys),
		.reset_delayed (reset_delayed),
		.pulse         (fdd_motor),
		.lit           (fdd_led)
	);

endmodule

`default_nettype wire

/* rtl/glue_core_pkg.sv */
`default_nettype none

package glue_core_pkg;

	// Enables toward the computer core, all on clk_sys
	typedef struct packed {
		logic       sys_ce;
		logic       mpu_cep;
		logic       mpu_cen;
		logic       snd_ce;
		logic [1:0] opm_ce;
	} clock_enables_t;

	// Bit order of mounted_delayed is floppy 0, floppy 1, hard disk, SRAM image
	typedef struct packed {
		logic [3:0] mounted_delayed;
		logic [1:0] floppy_ejected;
	} disk_status_t;

	////////////////////////////////////////
	// Loader path
	////////////////////////////////////////

	// Download write from the host side
	typedef struct packed {
		logic [19:0] addr;
		logic [7:0]  data;
		logic        wr;
	} loader_req_t;

	// Loader control toward the core
	typedef struct packed {
		logic aen;
		logic wr;
		logic done;
	} loader_ctl_t;

endpackage

`default_nettype wire

/* rtl/glue_menu_pkg.sv */
`default_nettype none

package glue_menu_pkg;

	////////////////////////////////////////
	// Status word bit positions
	////////////////////////////////////////

	localparam logic [5:0] POS_RESET      = 6'd0;
	localparam logic [5:0] POS_NMI        = 6'd7;
	localparam logic [5:0] POS_POWER      = 6'd8;
	localparam logic [5:0] POS_FDSYNC0    = 6'd9;
	localparam logic [5:0] POS_FDSYNC1    = 6'd10;
	localparam logic [5:0] POS_FDEJECT0   = 6'd11;
	localparam logic [5:0] POS_FDEJECT1   = 6'd12;
	localparam logic [5:0] POS_SRAM_LOAD  = 6'd13;
	localparam logic [5:0] POS_SRAM_STORE = 6'd14;

	// Upper half of the status word
	localparam logic [5:0] POS_TURBO      = 6'd32;
	localparam logic [5:0] POS_VIDEO_RATE = 6'd33;

	////////////////////////////////////////
	// Decoded menu content
	////////////////////////////////////////

	// Levels that follow the menu options
	typedef struct packed {
		logic turbo;
		logic video_rate;
	} menu_settings_t;

	// One-cycle strobes taken from status bit edges
	typedef struct packed {
		logic       nmi;
		logic       power;
		logic [1:0] fd_sync;
		logic [1:0] fd_eject;
		logic       sram_load;
		logic       sram_store;
		logic       reset_release;
	} menu_requests_t;

endpackage

`default_nettype wire

/* rtl/loader_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_bridge
	import glue_core_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset_delayed,
	input  logic        download,
	input  loader_req_t req,
	input  logic        core_ack,
	output loader_ctl_t ctl,
	output logic [19:0] core_addr,
	output logic [7:0]  core_data
);

	logic wr_q;
	logic done_q;
	logic download_q;
	logic ack_q;
	logic accept;

	// Writes after the loader has closed are dropped
	assign accept = req.wr & ~done_q;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			wr_q       <= 1'b0;
			done_q     <= 1'b0;
			download_q <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			download_q <= download;
			ack_q      <= core_ack;

			// A new write wins over the acknowledge of the previous one
			if (accept)
				wr_q <= 1'b1;
			else if (core_ack && !ack_q && wr_q)
				wr_q <= 1'b0;

			if (download_q && !download)
				done_q <= 1'b1;
		end
	end

	// Write payload
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			core_addr <= req.addr;
			core_data <= req.data;
		end
	end

	assign ctl.aen  = download & ~done_q;
	assign ctl.wr   = wr_q;
	assign ctl.done = done_q;

endmodule

`default_nettype wire

/* rtl/menu_status_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module menu_status_decode
	import glue_menu_pkg::*;
(
	input  logic           clk_sys,
	input  logic           reset_delayed,
	input  logic [63:0]    status,
	output menu_settings_t settings,
	output menu_requests_t requests,
	output logic           held_reset
);

	// Previous status word for edge detection
	logic [63:0] status_q;
	logic [63:0] rise;

	assign rise = status & ~status_q;

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			status_q   <= '0;
			settings   <= '0;
			requests   <= '0;
			held_reset <= 1'b0;
		end else begin
			status_q <= status;

			// Option levels
			settings.turbo      <= status[POS_TURBO];
			settings.video_rate <= status[POS_VIDEO_RATE];
			held_reset          <= status[POS_RESET];

			// Menu buttons act on their rising edge
			requests.nmi        <= rise[POS_NMI];
			requests.power      <= rise[POS_POWER];
			requests.fd_sync    <= {rise[POS_FDSYNC1], rise[POS_FDSYNC0]};
			requests.fd_eject   <= {rise[POS_FDEJECT1], rise[POS_FDEJECT0]};
			requests.sram_load  <= rise[POS_SRAM_LOAD];
			requests.sram_store <= rise[POS_SRAM_STORE];

			// Reset is released when the menu reset bit drops
			requests.reset_release <= status_q[POS_RESET] & ~status[POS_RESET];
		end
	end

endmodule

`default_nettype wire

/* rtl/reset_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer
	import glue_menu_pkg::*;
	import glue_core_pkg::*;
#(
	parameter logic [23:0] MOUNT_HOLD   = 24'hffffff,
	parameter int unsigned EJECT_WINDOW = 65536,
	parameter int unsigned EJECT_HOLD   = 65535,
	parameter int unsigned RESET_HOLD   = 65535
) (
	input  logic           clk_sys,
	input  logic           reset_delayed,
	input  menu_requests_t requests,
	input  logic           held_reset,
	input  logic           user_button,
	input  logic           ext_reset,
	input  logic           download,
	input  logic [3:0]     img_mounted,
	output disk_status_t   disks,
	output logic           core_reset,
	output logic           core_run
);

	// Mount counts above this value still read as ejected
	localparam logic [23:0] EJECT_LIMIT = MOUNT_HOLD - 24'(EJECT_WINDOW);

	logic [23:0] mount_cnt [4];
	logic [15:0] eject_cnt [2];
	logic [15:0] reset_hold;

	logic       hdd_mounted_q;
	logic       download_q;
	logic       init_released;
	logic [1:0] floppy_ejected;

	////////////////////////////////////////
	// Delayed disk view
	////////////////////////////////////////

	// A fresh floppy looks ejected first so the core sees a media change
	assign floppy_ejected[0] = (mount_cnt[0] > EJECT_LIMIT) || (eject_cnt[0] != '0);
	assign floppy_ejected[1] = (mount_cnt[1] > EJECT_LIMIT) || (eject_cnt[1] != '0);

	assign disks.floppy_ejected     = floppy_ejected;
	assign disks.mounted_delayed[0] = ~floppy_ejected[0] && (mount_cnt[0] != '0);
	assign disks.mounted_delayed[1] = ~floppy_ejected[1] && (mount_cnt[1] != '0);
	assign disks.mounted_delayed[2] = (mount_cnt[2] != '0);
	assign disks.mounted_delayed[3] = (mount_cnt[3] != '0);

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			for (int i = 0; i < 4; i++) begin
				mount_cnt[i] <= '0;
			end
			for (int i = 0; i < 2; i++) begin
				eject_cnt[i] <= '0;
			end
			reset_hold    <= '0;
			hdd_mounted_q <= 1'b0;
		end else begin
			hdd_mounted_q <= img_mounted[2];

			// A new mount pulse restarts the hold
			for (int i = 0; i < 4; i++) begin
				if (img_mounted[i])
					mount_cnt[i] <= MOUNT_HOLD;
				else if (mount_cnt[i] != '0)
					mount_cnt[i] <= mount_cnt[i] - 24'd1;
			end

			for (int i = 0; i < 2; i++) begin
				if (requests.fd_eject[i])
					eject_cnt[i] <= 16'(EJECT_HOLD);
				else if (eject_cnt[i] != '0)
					eject_cnt[i] <= eject_cnt[i] - 16'd1;
			end

			// Hard disk swap forces the core through a reset
			if (img_mounted[2] && !hdd_mounted_q)
				reset_hold <= 16'(RESET_HOLD);
			else if (reset_hold != '0)
				reset_hold <= reset_hold - 16'd1;
		end
	end

	////////////////////////////////////////
	// Core reset and run
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			download_q    <= 1'b0;
			init_released <= 1'b0;
			core_run      <= 1'b0;
			core_reset    <= 1'b1;
		end else begin
			download_q <= download;

			if (requests.reset_release)
				init_released <= 1'b1;

			// First download starts the machine
			if (download && !download_q)
				core_run <= 1'b1;

			core_reset <= user_button | held_reset | ext_reset | ~init_released
				| (reset_hold != '0);
		end
	end

endmodule

`default_nettype wire

/* tb.f */
rtl/glue_menu_pkg.sv
rtl/glue_core_pkg.sv
rtl/menu_status_decode.sv
rtl/clock_enable_gen.sv
rtl/reset_sequencer.sv
rtl/loader_bridge.sv
rtl/activity_led.sv
rtl/core_glue.sv
testbench/core_glue_asserts.sv
testbench/tb_core_glue.sv

/* testbench/core_glue_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module core_glue_asserts
	import glue_menu_pkg::*;
	import glue_core_pkg::*;
#(
	parameter int unsigned MOUNT_HOLD   = 24'hffffff,
	parameter int unsigned EJECT_WINDOW = 65536,
	parameter int unsigned EJECT_HOLD   = 65535,
	parameter int unsigned RESET_HOLD   = 65535,
	parameter int unsigned LED_HOLD     = 4500000
) (
	input logic           clk_sys,
	input logic           reset_delayed,
	input logic [63:0]    status,
	input logic           user_button,
	input logic [3:0]     img_mounted,
	input logic           download,
	input loader_req_t    loader_req,
	input logic           core_ack,
	input logic           snd_clockmode,
	input logic           hdd_activity,
	input logic           fdd_motor,
	input clock_enables_t enables,
	input disk_status_t   disks,
	input logic           core_reset,
	input logic           core_run,
	input loader_ctl_t    loader_ctl,
	input logic [19:0]    core_addr,
	input logic [7:0]     core_data,
	input logic           hdd_led,
	input logic           fdd_led,
	input menu_requests_t requests
);

	int unsigned fail_count;

	// Cycle counts since a setting changed or an enable fired
	logic [4:0] turbo_age;
	logic [4:0] mode_age;
	logic [4:0] cep_gap;
	logic [4:0] snd_gap;
	logic       turbo_prev;
	logic       mode_prev;
	logic       reset_prev;
	logic       rel_seen;
	logic       turbo_steady;
	logic       mode_steady;

	function automatic logic [4:0] sat_inc(input logic [4:0] v);
		return (v == 5'd31) ? v : v + 5'd1;
	endfunction

	task automatic count_failure(input string what);
		fail_count++;
		$error("[ERROR] %0t %s", $time, what);
	endtask

	initial fail_count = 0;

	assign turbo_steady = (turbo_age > 5'd15) && (status[POS_TURBO] == turbo_prev);
	assign mode_steady  = (mode_age > 5'd15) && (snd_clockmode == mode_prev);

	always_ff @(posedge clk_sys) begin
		if (reset_delayed) begin
			turbo_age  <= '0;
			mode_age   <= '0;
			cep_gap    <= '0;
			snd_gap    <= '0;
			turbo_prev <= 1'b0;
			mode_prev  <= 1'b0;
			reset_prev <= 1'b0;
			rel_seen   <= 1'b0;
		end else begin
			turbo_prev <= status[POS_TURBO];
			mode_prev  <= snd_clockmode;
			reset_prev <= status[POS_RESET];
			turbo_age  <= (status[POS_TURBO] != turbo_prev) ? 5'd0 : sat_inc(turbo_age);
			mode_age   <= (snd_clockmode != mode_prev) ? 5'd0 : sat_inc(mode_age);
			cep_gap    <= enables.mpu_cep ? 5'd1 : sat_inc(cep_gap);
			snd_gap    <= enables.snd_ce ? 5'd1 : sat_inc(snd_gap);
			if (reset_prev && !status[POS_RESET])
				rel_seen <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Reset state and enables
	////////////////////////////////////////

	assert property (@(posedge clk_sys) reset_delayed |=> core_reset && enables == '0
		&& disks == '0 && !loader_ctl.wr && !loader_ctl.done && !core_run && !hdd_led && !fdd_led)
		else count_failure("outputs not at reset values");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		enables.sys_ce |=> !enables.sys_ce [*3] ##1 enables.sys_ce)
		else count_failure("sys_ce period is not 4");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		enables.mpu_cep && turbo_steady && !status[POS_TURBO] |-> cep_gap == 5'd4 ##2 enables.mpu_cen)
		else count_failure("mpu enables wrong with turbo off");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		turbo_steady && status[POS_TURBO] |-> enables.mpu_cep != enables.mpu_cen)
		else count_failure("mpu enables do not alternate in turbo");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		enables.opm_ce[0] |=> !enables.opm_ce[0] [*9] ##1 enables.opm_ce[0])
		else count_failure("opm_ce[0] period is not 10");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		enables.opm_ce[1] |=> !enables.opm_ce[1] [*19] ##1 enables.opm_ce[1])
		else count_failure("opm_ce[1] period is not 20");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		enables.snd_ce && mode_steady |-> snd_gap == (snd_clockmode ? 5'd10 : 5'd5))
		else count_failure("snd_ce period does not follow the sound clock mode");

	////////////////////////////////////////
	// Menu request strobes
	////////////////////////////////////////

	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(status[POS_NMI]) |=> requests.nmi ##1 !requests.nmi)
		else count_failure("nmi request is not a one-cycle strobe");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(status[POS_POWER]) |=> requests.power ##1 !requests.power)
		else count_failure("power request is not a one-cycle strobe");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(status[POS_SRAM_LOAD]) |=> requests.sram_load ##1 !requests.sram_load)
		else count_failure("sram_load request is not a one-cycle strobe");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(status[POS_SRAM_STORE]) |=> requests.sram_store ##1 !requests.sram_store)
		else count_failure("sram_store request is not a one-cycle strobe");

	////////////////////////////////////////
	// Disks, reset and run
	////////////////////////////////////////

	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		img_mounted[2] |=> disks.mounted_delayed[2] [*MOUNT_HOLD] ##1 !disks.mounted_delayed[2])
		else count_failure("hard disk mount hold has the wrong length");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(img_mounted[2]) && !core_reset |=> ##1 core_reset [*RESET_HOLD] ##1 !core_reset)
		else count_failure("hard disk reset hold has the wrong length");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		img_mounted[0] |=> (disks.floppy_ejected[0] && !disks.mounted_delayed[0]) [*EJECT_WINDOW]
		##1 (!disks.floppy_ejected[0] && disks.mounted_delayed[0]) [*MOUNT_HOLD - EJECT_WINDOW]
		##1 !disks.mounted_delayed[0])
		else count_failure("floppy 0 mount view is wrong");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(status[POS_FDEJECT1]) |=> ##1 disks.floppy_ejected[1] [*EJECT_HOLD]
		##1 !disks.floppy_ejected[1])
		else count_failure("floppy 1 eject has the wrong length");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		!rel_seen |-> core_reset)
		else count_failure("core_reset dropped before the reset bit was released");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$fell(status[POS_RESET]) && !rel_seen && !user_button |-> core_reset [*3] ##1 !core_reset)
		else count_failure("core_reset did not follow the reset release");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		user_button |=> core_reset)
		else count_failure("user button did not reset the core");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(download) |=> core_run)
		else count_failure("core_run did not rise with the download");

	////////////////////////////////////////
	// Loader and indicators
	////////////////////////////////////////

	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		loader_req.wr && !loader_ctl.done |=> loader_ctl.wr
		&& core_addr == $past(loader_req.addr) && core_data == $past(loader_req.data))
		else count_failure("loader write not passed to the core");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		loader_ctl.wr && !loader_req.wr && !$rose(core_ack) |=> loader_ctl.wr)
		else count_failure("loader wr dropped without acknowledge");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		loader_ctl.wr && !loader_req.wr && $rose(core_ack) |=> !loader_ctl.wr)
		else count_failure("loader wr did not fall after acknowledge");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$rose(download) && !loader_ctl.done |-> loader_ctl.aen)
		else count_failure("loader address enable not raised by the download");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		$fell(download) |=> loader_ctl.done)
		else count_failure("loader done not set after download");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		loader_ctl.done |=> loader_ctl.done)
		else count_failure("loader done did not stay set");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		loader_ctl.done && !loader_ctl.wr |=> !loader_ctl.wr)
		else count_failure("write accepted after loader done");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		hdd_activity |=> hdd_led [*LED_HOLD])
		else count_failure("hdd_led not lit for the hold time");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		hdd_activity ##1 !hdd_activity [*LED_HOLD] |=> !hdd_led)
		else count_failure("hdd_led stayed lit too long");
	assert property (@(posedge clk_sys) disable iff (reset_delayed)
		fdd_motor |=> fdd_led [*LED_HOLD])
		else count_failure("fdd_led not lit for the hold time");

endmodule

`default_nettype wire

/* testbench/tb_core_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core_glue
	import glue_menu_pkg::*;
	import glue_core_pkg::*;
();

	localparam int WR_HIGH     = 0;
	localparam int WR_LOW      = 1;
	localparam int RESET_LOW   = 2;
	localparam int LOADER_DONE = 3;

	logic           clk_sys;
	logic           reset_delayed;
	logic [63:0]    status;
	logic           ext_reset;
	logic           user_button;
	logic [3:0]     img_mounted;
	logic           download;
	loader_req_t    loader_req;
	logic           core_ack;
	logic           snd_clockmode;
	logic           hdd_activity;
	logic           fdd_motor;
	clock_enables_t enables;
	disk_status_t   disks;
	logic           core_reset;
	logic           core_run;
	loader_ctl_t    loader_ctl;
	logic [19:0]    core_addr;
	logic [7:0]     core_data;
	logic           hdd_led;
	logic           fdd_led;
	menu_requests_t requests;

	int unsigned timeouts;
	int unsigned failures;

	core_glue #(
		.MOUNT_HOLD   (24'd40),
		.EJECT_WINDOW (10),
		.EJECT_HOLD   (6),
		.RESET_HOLD   (12),
		.LED_HOLD     (8)
	) dut (.*);

	bind core_glue core_glue_asserts #(
		.MOUNT_HOLD   (MOUNT_HOLD),
		.EJECT_WINDOW (EJECT_WINDOW),
		.EJECT_HOLD   (EJECT_HOLD),
		.RESET_HOLD   (RESET_HOLD),
		.LED_HOLD     (LED_HOLD)
	) u_asserts (.*);

	always #50 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic condition_met(input int what);
		case (what)
			WR_HIGH:   return loader_ctl.wr;
			WR_LOW:    return !loader_ctl.wr;
			RESET_LOW: return !core_reset;
			default:   return loader_ctl.done;
		endcase
	endfunction

	// Outputs are looked at on the falling edge, away from the update
	task automatic wait_for(input int what, input string name, input int limit);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!condition_met(what) && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (!condition_met(what)) begin
			timeouts++;
			$display("Timeout at %0t: gave up waiting for %s", $time, name);
		end
	endtask

	task automatic run_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic pulse_status(input int pos, input int len);
		@(posedge clk_sys);
		status[pos] <= 1'b1;
		repeat (len) @(posedge clk_sys);
		status[pos] <= 1'b0;
	endtask

	task automatic pulse_mount(input int unit);
		@(posedge clk_sys);
		img_mounted[unit] <= 1'b1;
		@(posedge clk_sys);
		img_mounted[unit] <= 1'b0;
	endtask

	task automatic host_write();
		@(posedge clk_sys);
		loader_req.addr <= 20'($urandom);
		loader_req.data <= 8'($urandom);
		loader_req.wr   <= 1'b1;
		@(posedge clk_sys);
		loader_req.wr <= 1'b0;
	endtask

	task automatic core_acknowledge();
		int delay;
		delay = $urandom_range(4, 1);
		repeat (delay) @(posedge clk_sys);
		core_ack <= 1'b1;
		@(posedge clk_sys);
		core_ack <= 1'b0;
	endtask

	task automatic pulse_hdd_activity();
		@(posedge clk_sys);
		hdd_activity <= 1'b1;
		@(posedge clk_sys);
		hdd_activity <= 1'b0;
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		clk_sys       = 1'b0;
		reset_delayed = 1'b1;
		status        = '0;
		ext_reset     = 1'b0;
		user_button   = 1'b0;
		img_mounted   = '0;
		download      = 1'b0;
		loader_req    = '0;
		core_ack      = 1'b0;
		snd_clockmode = 1'b0;
		hdd_activity  = 1'b0;
		fdd_motor     = 1'b0;
		timeouts      = 0;
		void'($urandom(32'h9481eb7c));

		repeat (2) @(posedge clk_sys);
		reset_delayed <= 1'b0;

		// Core leaves reset only after the menu reset bit is released
		run_cycles(6);
		pulse_status(POS_RESET, 3);
		wait_for(RESET_LOW, "core reset release", 10);
		@(posedge clk_sys);
		user_button <= 1'b1;
		@(posedge clk_sys);
		user_button <= 1'b0;

		// Menu buttons become one-cycle request strobes
		pulse_status(POS_NMI, 2);
		pulse_status(POS_POWER, 2);
		pulse_status(POS_SRAM_LOAD, 2);
		pulse_status(POS_SRAM_STORE, 2);

		// Enables in each turbo and sound mode
		run_cycles(40);
		@(posedge clk_sys);
		status[POS_TURBO] <= 1'b1;
		run_cycles(40);
		@(posedge clk_sys);
		snd_clockmode <= 1'b1;
		run_cycles(40);

		pulse_mount(2);
		run_cycles(60);
		pulse_mount(0);
		run_cycles(50);
		pulse_status(POS_FDEJECT1, 2);
		run_cycles(15);

		// Download with paced writes
		@(posedge clk_sys);
		download <= 1'b1;
		run_cycles(2);
		for (int i = 0; i < 4; i++) begin
			host_write();
			wait_for(WR_HIGH, "loader write strobe", 5);
			core_acknowledge();
			wait_for(WR_LOW, "loader write acknowledge", 5);
		end
		@(posedge clk_sys);
		download <= 1'b0;
		wait_for(LOADER_DONE, "loader done", 10);
		host_write();
		run_cycles(4);

		pulse_hdd_activity();
		run_cycles(4);
		pulse_hdd_activity();
		@(posedge clk_sys);
		fdd_motor <= 1'b1;
		@(posedge clk_sys);
		fdd_motor <= 1'b0;
		run_cycles(15);

		failures = dut.u_asserts.fail_count;
		$display("Assertion failures: %0d, timeouts: %0d", failures, timeouts);
		if (failures == 0 && timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
